//--- design/snn_pkg.sv
package snn_pkg;

    // ####################################################################
    // network sizes
    // ####################################################################
    localparam int img_side          = 4;
    localparam int img_pixels        = img_side * img_side;
    localparam int images_per_branch = 3;
    localparam int num_branches      = 2;
    localparam int num_images        = images_per_branch * num_branches;
    localparam int beats_per_test    = num_images * img_pixels;
    localparam int kernel_side       = 3;
    localparam int kernel_taps       = kernel_side * kernel_side;
    localparam int kernel_values     = kernel_taps * images_per_branch;
    localparam int weight_values     = 4;
    localparam int pool_outputs      = 4;

    // ####################################################################
    // fixed-point types
    // ####################################################################
    typedef logic signed [7:0]  pixel_t;
    typedef logic signed [7:0]  coef_t;
    // nine 16-bit products summed over three images
    typedef logic signed [23:0] fmap_t;
    typedef logic signed [35:0] fc_t;
    typedef logic        [39:0] dist_t;

    typedef pixel_t window_t [kernel_taps];
    typedef coef_t  kernel_t [kernel_taps];
    typedef coef_t  weight_t [weight_values];
    typedef fc_t    fc_vec_t [pool_outputs];

endpackage

//--- design/snn_loader.sv
`timescale 1ns/1ps

module snn_loader (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  snn_pkg::pixel_t   img,
    input  snn_pkg::coef_t    kernel,
    input  snn_pkg::coef_t    weight,
    input  logic              pad_zero,
    output logic              window_valid,
    output snn_pkg::window_t  window,
    output snn_pkg::kernel_t  taps,
    output logic [3:0]        position,
    output logic              branch_sel,
    output logic              first_image,
    output snn_pkg::weight_t  weights,
    output logic              sweep_done
);

    // beat 0..95 within a test, [6:4] is the image, [3:0] the pixel
    logic [6:0] beat;
    logic [6:0] run_len;
    logic       image_end;

    snn_pkg::pixel_t  img_buf [2][snn_pkg::img_pixels];
    snn_pkg::coef_t   kernel_buf [snn_pkg::kernel_values];
    snn_pkg::weight_t weight_buf;
    logic             pad_reg;

    logic       sweep_active;
    logic [3:0] sweep_pos;
    logic [2:0] sweep_img;
    logic       sweep_pad;

    logic [1:0]       kgrp;
    logic [4:0]       kbase;
    snn_pkg::window_t win_next;

    assign image_end = in_valid && (beat[3:0] == 4'hf);

    // ####################################################################
    // input capture
    // ####################################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat <= '0;
        end else if (in_valid) begin
            if (beat == 7'(snn_pkg::beats_per_test - 1))
                beat <= '0;
            else
                beat <= beat + 7'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            // ping-pong on image index bit 0
            img_buf[beat[4]][beat[3:0]] <= img;
            if (beat < 7'(snn_pkg::kernel_values))
                kernel_buf[beat[4:0]] <= kernel;
            if (beat < 7'(snn_pkg::weight_values))
                weight_buf[beat[1:0]] <= weight;
            if (beat == '0)
                pad_reg <= pad_zero;
        end
        // per-image padding mode, survives an overlapping next test
        if (image_end)
            sweep_pad <= pad_reg;
        // hand weights over at the last beat so the next test can refill
        if (image_end && beat[6:4] == 3'(snn_pkg::num_images - 1))
            weights <= weight_buf;
    end

    // ####################################################################
    // sweep control, 16 windows per image in raster order
    // ####################################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sweep_active <= 1'b0;
            sweep_pos    <= '0;
            sweep_img    <= '0;
        end else if (image_end) begin
            sweep_active <= 1'b1;
            sweep_pos    <= '0;
            sweep_img    <= beat[6:4];
        end else if (sweep_active) begin
            sweep_pos <= sweep_pos + 4'd1;
            if (sweep_pos == 4'hf)
                sweep_active <= 1'b0;
        end
    end

    // kernel k mod 3
    always_comb begin
        if (sweep_img >= 3'(snn_pkg::images_per_branch))
            kgrp = 2'(sweep_img - 3'(snn_pkg::images_per_branch));
        else
            kgrp = sweep_img[1:0];
        kbase = 5'(kgrp * snn_pkg::kernel_taps);
    end

    // 3x3 neighbourhood with edge replication or zero fill
    always_comb begin
        int   rr;
        int   cc;
        logic off;
        for (int t = 0; t < snn_pkg::kernel_taps; t++) begin
            rr  = int'(sweep_pos[3:2]) + t / snn_pkg::kernel_side - 1;
            cc  = int'(sweep_pos[1:0]) + t % snn_pkg::kernel_side - 1;
            off = (rr < 0) || (rr >= snn_pkg::img_side) ||
                  (cc < 0) || (cc >= snn_pkg::img_side);
            if (rr < 0)
                rr = 0;
            else if (rr >= snn_pkg::img_side)
                rr = snn_pkg::img_side - 1;
            if (cc < 0)
                cc = 0;
            else if (cc >= snn_pkg::img_side)
                cc = snn_pkg::img_side - 1;
            if (off && sweep_pad)
                win_next[t] = '0;
            else
                win_next[t] = img_buf[sweep_img[0]][4'(rr * snn_pkg::img_side + cc)];
        end
    end

    // ####################################################################
    // registered window outputs
    // ####################################################################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window_valid <= 1'b0;
            sweep_done   <= 1'b0;
        end else begin
            window_valid <= sweep_active;
            sweep_done   <= sweep_active && (sweep_pos == 4'hf) &&
                            (sweep_img == 3'(snn_pkg::num_images - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (sweep_active) begin
            window      <= win_next;
            position    <= sweep_pos;
            branch_sel  <= (sweep_img >= 3'(snn_pkg::images_per_branch));
            first_image <= (kgrp == 2'd0);
            for (int t = 0; t < snn_pkg::kernel_taps; t++)
                taps[t] <= kernel_buf[kbase + 5'(t)];
        end
    end

    // consecutive in_valid cycles, only for the check below
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            run_len <= '0;
        else if (in_valid)
            run_len <= run_len + 7'd1;
        else
            run_len <= '0;
    end

    // one test is exactly 96 beats, a burst never runs into the next
    a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> run_len < 7'(snn_pkg::beats_per_test))
        else $error("in_valid high for more than one test");

endmodule

//--- design/snn_branch.sv
`timescale 1ns/1ps

module snn_branch #(
    parameter int unsigned branch_index = 0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              window_valid,
    input  snn_pkg::window_t  window,
    input  snn_pkg::kernel_t  taps,
    input  logic [3:0]        position,
    input  logic              branch_sel,
    input  logic              first_image,
    input  logic              sweep_done,
    input  snn_pkg::weight_t  weights,
    output snn_pkg::fc_vec_t  fc_result,
    output logic              fc_valid
);

    snn_pkg::fmap_t fmap [snn_pkg::img_pixels];
    snn_pkg::fmap_t dot;
    snn_pkg::fmap_t pooled [snn_pkg::pool_outputs];
    snn_pkg::fc_vec_t fc_next;
    logic            own_window;
    logic            done_q;

    assign own_window = window_valid && (branch_sel == 1'(branch_index));

    // ####################################################################
    // convolution and accumulation
    // ####################################################################
    always_comb begin
        dot = '0;
        for (int t = 0; t < snn_pkg::kernel_taps; t++)
            dot = dot + snn_pkg::fmap_t'(window[t]) * snn_pkg::fmap_t'(taps[t]);
    end

    // first image of the branch overwrites, the previous test's map is dropped
    always_ff @(posedge clk) begin
        if (own_window) begin
            if (first_image)
                fmap[position] <= dot;
            else
                fmap[position] <= fmap[position] + dot;
        end
    end

    // ####################################################################
    // 2x2 max pooling and fully connected layer
    // ####################################################################
    function automatic snn_pkg::fmap_t max2(input snn_pkg::fmap_t a, input snn_pkg::fmap_t b);
        return (a > b) ? a : b;
    endfunction

    always_comb begin
        int base;
        for (int q = 0; q < snn_pkg::pool_outputs; q++) begin
            // top-left entry of quadrant q
            base = (q / 2) * 2 * snn_pkg::img_side + (q % 2) * 2;
            pooled[q] = max2(max2(fmap[base], fmap[base + 1]),
                             max2(fmap[base + snn_pkg::img_side],
                                  fmap[base + snn_pkg::img_side + 1]));
        end
    end

    // out[o] = p[2r] * w[c] + p[2r+1] * w[c+2], r = o / 2, c = o % 2
    always_comb begin
        int r;
        int c;
        for (int o = 0; o < snn_pkg::pool_outputs; o++) begin
            r = o / 2;
            c = o % 2;
            fc_next[o] = snn_pkg::fc_t'(pooled[2 * r]) * snn_pkg::fc_t'(weights[c]) +
                         snn_pkg::fc_t'(pooled[2 * r + 1]) * snn_pkg::fc_t'(weights[c + 2]);
        end
    end

    // map holds its last window one cycle after sweep_done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q   <= 1'b0;
            fc_valid <= 1'b0;
        end else begin
            done_q   <= sweep_done;
            fc_valid <= done_q;
        end
    end

    always_ff @(posedge clk) begin
        if (done_q)
            fc_result <= fc_next;
    end

    // one result per test
    a_fc_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        fc_valid |=> !fc_valid)
        else $error("fc_valid held for more than one cycle");

endmodule

//--- design/snn_distance.sv
`timescale 1ns/1ps

module snn_distance (
    input  logic              clk,
    input  logic              rst_n,
    input  snn_pkg::fc_vec_t  fc_a,
    input  snn_pkg::fc_vec_t  fc_b,
    input  logic              fc_valid,
    output snn_pkg::dist_t    out,
    output logic              out_valid
);

    snn_pkg::dist_t l1_sum;

    // ####################################################################
    // L1 distance over the four outputs
    // ####################################################################
    always_comb begin
        // one extra bit so the difference cannot overflow
        logic signed [$bits(snn_pkg::fc_t):0] diff;
        l1_sum = '0;
        for (int i = 0; i < snn_pkg::pool_outputs; i++) begin
            diff = ($bits(diff))'(fc_a[i]) - ($bits(diff))'(fc_b[i]);
            if (diff < 0)
                diff = -diff;
            l1_sum = l1_sum + snn_pkg::dist_t'(diff);
        end
    end

    // out only carries a value in the valid cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out       <= '0;
        end else if (fc_valid) begin
            out_valid <= 1'b1;
            out       <= l1_sum;
        end else begin
            out_valid <= 1'b0;
            out       <= '0;
        end
    end

    a_out_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> out == '0)
        else $error("out nonzero while out_valid is low");

endmodule

//--- design/snn_top.sv
`timescale 1ns/1ps

module snn_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  snn_pkg::pixel_t   img,
    input  snn_pkg::coef_t    kernel,
    input  snn_pkg::coef_t    weight,
    input  logic              pad_zero,
    output logic              out_valid,
    output snn_pkg::dist_t    out
);

    // loader to branches
    logic             window_valid;
    snn_pkg::window_t window;
    snn_pkg::kernel_t taps;
    logic [3:0]       position;
    logic             branch_sel;
    logic             first_image;
    snn_pkg::weight_t weights;
    logic             sweep_done;

    // branches to distance unit
    snn_pkg::fc_vec_t fc_result [snn_pkg::num_branches];
    logic             fc_valid  [snn_pkg::num_branches];

    snn_loader i_loader (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .img          (img),
        .kernel       (kernel),
        .weight       (weight),
        .pad_zero     (pad_zero),
        .window_valid (window_valid),
        .window       (window),
        .taps         (taps),
        .position     (position),
        .branch_sel   (branch_sel),
        .first_image  (first_image),
        .weights      (weights),
        .sweep_done   (sweep_done)
    );

    // ####################################################################
    // one branch per Siamese side
    // ####################################################################
    for (genvar b = 0; b < snn_pkg::num_branches; b++) begin : g_branch
        snn_branch #(
            .branch_index (b)
        ) i_branch (
            .clk          (clk),
            .rst_n        (rst_n),
            .window_valid (window_valid),
            .window       (window),
            .taps         (taps),
            .position     (position),
            .branch_sel   (branch_sel),
            .first_image  (first_image),
            .sweep_done   (sweep_done),
            .weights      (weights),
            .fc_result    (fc_result[b]),
            .fc_valid     (fc_valid[b])
        );
    end

    // both sides finish on the same sweep_done
    snn_distance i_distance (
        .clk       (clk),
        .rst_n     (rst_n),
        .fc_a      (fc_result[0]),
        .fc_b      (fc_result[1]),
        .fc_valid  (fc_valid[0]),
        .out       (out),
        .out_valid (out_valid)
    );

endmodule

//--- verif/snn_tb.sv
`timescale 1ns/1ps

module snn_tb;

    localparam int max_tests       = 16;
    localparam int beats           = snn_pkg::beats_per_test;
    localparam int latency         = 19;
    localparam int cycles_per_test = 125;
    localparam int margin_cycles   = 100;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    snn_pkg::pixel_t img;
    snn_pkg::coef_t  kernel;
    snn_pkg::coef_t  weight;
    logic            pad_zero;
    logic            out_valid;
    snn_pkg::dist_t  out;

    // test vectors as read from the data file
    string          name_mem [max_tests];
    int             pix_mem  [max_tests][beats];
    int             kern_mem [max_tests][snn_pkg::kernel_values];
    int             wt_mem   [max_tests][snn_pkg::weight_values];
    logic           pad_mem  [max_tests];
    snn_pkg::dist_t exp_mem  [max_tests];
    snn_pkg::dist_t act_mem  [max_tests];

    int   num_tests;
    int   errors;
    int   tests_ok;
    int   pulse_count;
    int   cycle_count;
    int   limit_cycles;
    logic out_valid_q;

    snn_top i_snn_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .img       (img),
        .kernel    (kernel),
        .weight    (weight),
        .pad_zero  (pad_zero),
        .out_valid (out_valid),
        .out       (out)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ####################################################################
    // compare tasks
    // ####################################################################
    task automatic check_dist(input string name, input snn_pkg::dist_t actual,
                              input snn_pkg::dist_t expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %0b, actual %0b", name, expected, actual);
            errors++;
        end
    endtask

    // ####################################################################
    // data file reader
    // ####################################################################
    task automatic load_tests();
        int     fd;
        int     code;
        int     bad;
        longint lv;
        string  tok;
        string  rest;
        fd  = $fopen("verif/snn_input.txt", "r");
        bad = 0;
        num_tests = 0;
        if (fd == 0) begin
            $display("cannot open verif/snn_input.txt");
            errors++;
        end else begin
            while (!$feof(fd) && num_tests < max_tests) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1)
                    break;
                // skip the rest of a comment line
                if (tok.getc(0) == "#") begin
                    code = $fgets(rest, fd);
                    continue;
                end
                name_mem[num_tests] = tok;
                code = $fscanf(fd, "%d", lv);
                bad += (code != 1);
                pad_mem[num_tests] = (lv != 0);
                for (int b = 0; b < beats; b++) begin
                    code = $fscanf(fd, "%d", pix_mem[num_tests][b]);
                    bad += (code != 1);
                end
                for (int k = 0; k < snn_pkg::kernel_values; k++) begin
                    code = $fscanf(fd, "%d", kern_mem[num_tests][k]);
                    bad += (code != 1);
                end
                for (int w = 0; w < snn_pkg::weight_values; w++) begin
                    code = $fscanf(fd, "%d", wt_mem[num_tests][w]);
                    bad += (code != 1);
                end
                code = $fscanf(fd, "%d", lv);
                bad += (code != 1);
                exp_mem[num_tests] = snn_pkg::dist_t'(lv);
                if (bad != 0) begin
                    $display("malformed data for test %s", tok);
                    errors++;
                    bad = 0;
                end
                num_tests++;
            end
            $fclose(fd);
        end
    endtask

    // ####################################################################
    // one test is 96 beats and then 19 cycles to the result
    // ####################################################################
    task automatic run_test(input int t);
        int first_err;
        bit same_pix;
        first_err = errors;
        // beat 0 goes out on the current falling edge
        for (int b = 0; b < beats; b++) begin
            if (b > 0)
                @(negedge clk);
            in_valid = 1'b1;
            pad_zero = pad_mem[t];
            img      = snn_pkg::pixel_t'(pix_mem[t][b]);
            kernel   = '0;
            weight   = '0;
            if (b < snn_pkg::kernel_values)
                kernel = snn_pkg::coef_t'(kern_mem[t][b]);
            if (b < snn_pkg::weight_values)
                weight = snn_pkg::coef_t'(wt_mem[t][b]);
        end
        // c counts rising edges after the one that takes the last beat
        for (int c = 0; c <= latency; c++) begin
            @(negedge clk);
            if (c == 0) begin
                in_valid = 1'b0;
                img      = '0;
                kernel   = '0;
                weight   = '0;
            end
            if (c < latency) begin
                check_flag({name_mem[t], " out_valid before latency"}, out_valid, 1'b0);
            end else begin
                check_flag({name_mem[t], " out_valid at latency"}, out_valid, 1'b1);
                check_dist({name_mem[t], " distance"}, out, exp_mem[t]);
                act_mem[t] = out;
            end
        end
        // zero padding on the images of a replication test must move the result
        if (t > 0 && pad_mem[t] && !pad_mem[t - 1]) begin
            same_pix = 1'b1;
            for (int b = 0; b < beats; b++)
                if (pix_mem[t][b] != pix_mem[t - 1][b])
                    same_pix = 1'b0;
            if (same_pix && act_mem[t] == act_mem[t - 1]) begin
                $display("zero padding in %s gave the same distance as replication",
                         name_mem[t]);
                errors++;
            end
        end
        if (errors == first_err)
            tests_ok++;
        $display("test %s done with %0d errors", name_mem[t], errors - first_err);
    endtask

    // idle output stays zero and out_valid is a single pulse
    always @(negedge clk) begin
        if (!rst_n) begin
            out_valid_q = 1'b0;
        end else begin
            if (!out_valid)
                check_dist("idle out", out, '0);
            if (out_valid && out_valid_q) begin
                $display("out_valid stayed high for two cycles in a row");
                errors++;
            end
            if (out_valid)
                pulse_count++;
            out_valid_q = out_valid;
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (limit_cycles > 0 && cycle_count >= limit_cycles) begin
            $display("timeout after %0d cycles without finishing the tests", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ####################################################################
    // main sequence
    // ####################################################################
    initial begin
        int gap;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        img          = '0;
        kernel       = '0;
        weight       = '0;
        pad_zero     = 1'b0;
        errors       = 0;
        tests_ok     = 0;
        pulse_count  = 0;
        cycle_count  = 0;
        limit_cycles = 0;
        out_valid_q  = 1'b0;
        void'($urandom(32'he0a1));
        load_tests();
        limit_cycles = num_tests * cycles_per_test + margin_cycles;

        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_flag("reset out_valid", out_valid, 1'b0);
        check_dist("reset out", out, '0);

        for (int t = 0; t < num_tests; t++) begin
            // odd tests follow right behind the previous result
            if (t > 0) begin
                if (t % 2 == 1)
                    gap = 0;
                else
                    gap = int'($urandom % 6);
                repeat (gap) @(negedge clk);
            end
            run_test(t);
        end

        repeat (2) @(negedge clk);
        if (pulse_count != num_tests) begin
            $display("expected %0d out_valid pulses, saw %0d", num_tests, pulse_count);
            errors++;
        end
        $display("tests passed %0d of %0d, errors %0d", tests_ok, num_tests, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- verif/snn_input.txt
# columns: name pad_zero then 96 pixels as six 4x4 images in raster order
# then 27 kernel values as three 3x3 kernels then 4 weights then the expected distance
rep_corner 0 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 1 4 1 5 9 2 6 5 3 5 8 9 7 9 3 -7 7 -7 7 2 -2 2 -2 12 -12 12 -12 1 0 -1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 5 8 6 4 2 0 -2 -4 -6 -8 -10 -12 -14 1 3 5 7 1 1 1 1 2 2 2 2 3 3 3 3 4 4 4 4 1 1 1 1 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 3 4 260
zero_corner 1 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 1 4 1 5 9 2 6 5 3 5 8 9 7 9 3 -7 7 -7 7 2 -2 2 -2 12 -12 12 -12 1 0 -1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 5 8 6 4 2 0 -2 -4 -6 -8 -10 -12 -14 1 3 5 7 1 1 1 1 2 2 2 2 3 3 3 3 4 4 4 4 1 1 1 1 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 3 4 65
same_sides 0 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 1 4 1 5 9 2 6 5 3 5 8 9 7 9 3 -7 7 -7 7 2 -2 2 -2 12 -12 12 -12 1 0 -1 0 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 1 4 1 5 9 2 6 5 3 5 8 9 7 9 3 -7 7 -7 7 2 -2 2 -2 12 -12 12 -12 1 0 -1 0 1 1 1 1 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 3 4 0
neg_corner 0 -10 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3 1 4 1 5 9 2 6 5 3 5 8 9 7 9 3 -7 7 -7 7 2 -2 2 -2 12 -12 12 -12 1 0 -1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 5 8 6 4 2 0 -2 -4 -6 -8 -10 -12 -14 1 3 5 7 1 1 1 1 2 2 2 2 3 3 3 3 4 4 4 4 1 1 1 1 1 1 1 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 3 4 170
accum_center 1 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 -7 7 -7 7 2 -2 2 -2 12 -12 12 -12 1 0 -1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 -1 1 1 1 1 2 2 2 2 3 3 3 3 4 4 4 4 0 0 0 0 1 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 2 -1 1 3 25

//--- sources.f
design/snn_pkg.sv
design/snn_loader.sv
design/snn_branch.sv
design/snn_distance.sv
design/snn_top.sv
verif/snn_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = snn_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_TEXT = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
